// File: flist.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/fetch_counter.sv
verilog/decode_stage.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/rv_core.sv
dv/clock_gen.sv
dv/rv_core_tb.sv

// File: dv/rv_core_tb.sv
`include "rv_config.svh"

module rv_core_tb
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int               RESET_LIMIT  = 20;
  localparam int               CYCLE_LIMIT  = 2000;
  localparam int               RANDOM_COUNT = 40;
  localparam logic [6:0]       SUB_F7       = 7'h20;
  localparam logic [`XLEN-1:0] PC_INC       = `PC_STEP;
  localparam logic [`XLEN-1:0] START_PC     = `RESET_PC;

  typedef struct packed {
    logic [`XLEN-1:0]      word;
    logic [`REG_IDX_W-1:0] rd;
    logic [`XLEN-1:0]      data;
    logic                  wr;
  } entry_t;

  logic                  clk;
  logic                  rst_n;
  logic [`XLEN-1:0]      instr;
  logic [`XLEN-1:0]      fetch_address;
  logic [`REG_IDX_W-1:0] dbg_sel;
  logic [`XLEN-1:0]      dbg_data;
  wb_t                   wb;

  logic [`XLEN-1:0] model_regs [0:`REG_COUNT-1];
  entry_t           program_q[$];
  logic [31:0]      lfsr_state = 32'h0b29a84e;
  logic [`XLEN-1:0] expected_fetch;
  int               check_count  = 0;
  int               error_count  = 0;
  int               fetch_checks = 0;
  int               fetch_errors = 0;
  int               test_checks;
  int               test_errors;
  bit               released;

  clock_gen u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rv_core uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr         (instr),
    .fetch_address (fetch_address),
    .dbg_sel       (dbg_sel),
    .dbg_data      (dbg_data),
    .wb            (wb)
  );

  // **************************************************************************
  // Instruction encoding and reference model
  // **************************************************************************

  function automatic logic [31:0] r_type_word(
    input logic [6:0] funct7,
    input logic [4:0] rs2,
    input logic [4:0] rs1,
    input logic [2:0] funct3,
    input logic [4:0] rd,
    input logic [6:0] opcode
  );
    instr_fields_t f;
    f.funct7 = funct7;
    f.rs2    = rs2;
    f.rs1    = rs1;
    f.funct3 = funct3;
    f.rd     = rd;
    f.opcode = opcode;
    return f;
  endfunction

  function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] funct3, input logic [4:0] rd,
                                              input logic [6:0] opcode);
    return r_type_word(imm[11:5], imm[4:0], rs1, funct3, rd, opcode);
  endfunction

  function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd);
    return r_type_word(imm[19:13], imm[12:8], imm[7:3], imm[2:0], rd, OPC_LUI);
  endfunction

  // ISA rules in program order, x0 never written
  task automatic predict(input logic [31:0] word, output entry_t e);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        wr;
    a   = model_regs[word[19:15]];
    b   = model_regs[word[24:20]];
    wr  = 1'b0;
    res = '0;
    if (word[6:0] == OPC_OP && word[14:12] == 3'b000) begin
      wr  = 1'b1;
      res = word[30] ? a - b : a + b;
    end else if (word[6:0] == OPC_OP_IMM && word[14:12] == 3'b000) begin
      wr  = 1'b1;
      res = a + {{20{word[31]}}, word[31:20]};
    end else if (word[6:0] == OPC_LUI) begin
      wr  = 1'b1;
      res = {word[31:12], 12'h000};
    end
    if (word[11:7] == 5'd0) begin
      wr = 1'b0;
    end
    if (wr) begin
      model_regs[word[11:7]] = res;
    end
    e.word = word;
    e.wr   = wr;
    e.rd   = wr ? word[11:7] : 5'd0;
    e.data = wr ? res : '0;
  endtask

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // **************************************************************************
  // Stimulus and checks
  // **************************************************************************

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR at %0.1f ns: %s is %h, expected %h", $realtime, name, actual, expected);
    end
  endtask

  // Next drive point, with the fetch address checked on every cycle
  task automatic step_cycle();
    int errs;
    @(posedge clk);
    #2;
    errs = error_count;
    expected_fetch = expected_fetch + PC_INC;
    compare("fetch_address", fetch_address, expected_fetch);
    fetch_checks++;
    if (error_count != errs) begin
      fetch_errors++;
    end
  endtask

  task automatic add_entry(input logic [31:0] word, input logic [4:0] rd,
                           input logic [31:0] data, input logic wr);
    entry_t e;
    predict(word, e);
    e.rd   = rd;
    e.data = data;
    e.wr   = wr;
    program_q.push_back(e);
  endtask

  task automatic add_random_instr();
    logic [31:0] op;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] imm;
    logic [31:0] word;
    entry_t      e;
    random_bits(2, op);
    random_bits(3, rd);
    random_bits(3, rs1);
    random_bits(3, rs2);
    random_bits(20, imm);
    case (op[1:0])
      2'd0:    word = r_type_word(7'h00, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP);
      2'd1:    word = r_type_word(SUB_F7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP);
      2'd2:    word = i_type_word(imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP_IMM);
      default: word = u_type_word(imm[19:0], rd[4:0]);
    endcase
    predict(word, e);
    program_q.push_back(e);
  endtask

  task automatic check_writeback(input entry_t e);
    compare("wb.valid", wb.valid, e.wr);
    if (e.wr) begin
      compare("wb.rd", wb.rd, e.rd);
      compare("wb.data", wb.data, e.data);
    end
  endtask

  // The writeback seen at a drive point belongs to the word sent three slots earlier
  task automatic run_program();
    int n;
    n = program_q.size();
    for (int t = 0; t < n + 3; t++) begin
      if (t >= 3) begin
        check_writeback(program_q[t-3]);
      end
      instr = (t < n) ? program_q[t].word : '0;
      step_cycle();
    end
    program_q.delete();
  endtask

  // One register per cycle, sampled mid-cycle
  task automatic read_back_regs();
    for (int i = 0; i < `REG_COUNT; i++) begin
      dbg_sel = i[`REG_IDX_W-1:0];
      @(negedge clk);
      compare($sformatf("dbg_data[x%0d]", i), dbg_data, model_regs[i]);
      step_cycle();
    end
    dbg_sel = '0;
  endtask

  task automatic wait_for_reset();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1 && waited < RESET_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    released = (rst_n === 1'b1);
  endtask

  task automatic begin_test();
    test_checks = check_count;
    test_errors = error_count;
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d mismatches", num, name,
             check_count - test_checks, error_count - test_errors);
  endtask

  initial begin : main
    instr   = '0;
    dbg_sel = '0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    wait_for_reset();
    if (!released) begin
      $display("reset was not released within %0d cycles", RESET_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end else begin
      // Before the first active edge
      begin_test();
      compare("fetch_address", fetch_address, START_PC);
      compare("wb.valid", wb.valid, 1'b0);
      expected_fetch = START_PC;
      step_cycle();
      read_back_regs();
      end_test(1, "reset");

      begin_test();
      add_entry(i_type_word(12'hffb, 0, 0, 1, OPC_OP_IMM), 1, 32'hffff_fffb, 1);
      add_entry(u_type_word(20'h12345, 2), 2, 32'h1234_5000, 1);
      add_entry(i_type_word(12'h678, 2, 0, 3, OPC_OP_IMM), 3, 32'h1234_5678, 1);
      add_entry(i_type_word(12'h800, 0, 0, 4, OPC_OP_IMM), 4, 32'hffff_f800, 1);
      add_entry(u_type_word(20'hfffff, 5), 5, 32'hffff_f000, 1);
      add_entry(i_type_word(12'hfff, 5, 0, 6, OPC_OP_IMM), 6, 32'hffff_efff, 1);
      run_program();
      end_test(3, "addi_lui");

      // Producers at distance 1, 2 and 3
      begin_test();
      add_entry(i_type_word(12'd100, 0, 0, 7, OPC_OP_IMM), 7, 32'd100, 1);
      add_entry(r_type_word(0, 7, 7, 0, 8, OPC_OP), 8, 32'd200, 1);
      add_entry(i_type_word(12'd3, 0, 0, 9, OPC_OP_IMM), 9, 32'd3, 1);
      add_entry(r_type_word(SUB_F7, 7, 8, 0, 10, OPC_OP), 10, 32'd100, 1);
      add_entry(r_type_word(SUB_F7, 8, 9, 0, 11, OPC_OP), 11, 32'hffff_ff3b, 1);
      add_entry(r_type_word(SUB_F7, 11, 0, 0, 12, OPC_OP), 12, 32'h0000_00c5, 1);
      add_entry(r_type_word(0, 11, 12, 0, 13, OPC_OP), 13, 32'd0, 1);
      add_entry(r_type_word(0, 13, 7, 0, 7, OPC_OP), 7, 32'd100, 1);
      add_entry(i_type_word(12'd1, 0, 0, 14, OPC_OP_IMM), 14, 32'd1, 1);
      add_entry(i_type_word(12'd1, 14, 0, 14, OPC_OP_IMM), 14, 32'd2, 1);
      add_entry(i_type_word(12'd1, 14, 0, 14, OPC_OP_IMM), 14, 32'd3, 1);
      add_entry(r_type_word(0, 14, 14, 0, 15, OPC_OP), 15, 32'd6, 1);
      add_entry(r_type_word(SUB_F7, 14, 0, 0, 16, OPC_OP), 16, 32'hffff_fffd, 1);
      run_program();
      end_test(4, "bypass");

      begin_test();
      add_entry(i_type_word(12'h005, 1, 0, 0, OPC_OP_IMM), 0, 0, 0);
      add_entry(r_type_word(0, 2, 1, 0, 0, OPC_OP), 0, 0, 0);
      add_entry(i_type_word(12'h010, 1, 3'b010, 3, 7'b0000011), 0, 0, 0);
      add_entry(i_type_word(12'h123, 0, 0, 1, 7'b1101111), 0, 0, 0);
      add_entry(r_type_word(0, 2, 1, 3'b100, 1, OPC_OP), 0, 0, 0);
      add_entry(i_type_word(12'h001, 2, 3'b001, 2, OPC_OP_IMM), 0, 0, 0);
      add_entry(u_type_word(20'habcde, 0), 0, 0, 0);
      add_entry(i_type_word(12'h000, 1, 0, 17, OPC_OP_IMM), 17, 32'hffff_fffb, 1);
      add_entry(r_type_word(0, 0, 0, 0, 18, OPC_OP), 18, 32'd0, 1);
      add_entry(i_type_word(12'h000, 3, 0, 19, OPC_OP_IMM), 19, 32'h1234_5678, 1);
      run_program();
      read_back_regs();
      end_test(5, "no_write");

      begin_test();
      for (int i = 0; i < RANDOM_COUNT; i++) begin
        add_random_instr();
      end
      run_program();
      read_back_regs();
      end_test(6, "random");

      $display("test 2 fetch: %0d checks, %0d mismatches", fetch_checks, fetch_errors);
      $display("tests: 6, checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
        $display("NO ERRORS");
      end else begin
        $display("ERRORS FOUND");
      end
      $finish;
    end
  end

  initial begin : watchdog
    for (int i = 0; i < CYCLE_LIMIT; i++) begin
      @(posedge clk);
    end
    $display("simulation did not finish within %0d cycles", CYCLE_LIMIT);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: dv/clock_gen.sv
module clock_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam real HALF_PERIOD  = 10.0;
  localparam int  RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Released 2 ns after the last reset edge, like the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
  end

endmodule

// File: verilog/rv_core.sv
`include "rv_config.svh"

module rv_core
  import rv_pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`XLEN-1:0]      instr,
  output logic [`XLEN-1:0]      fetch_address,
  input  logic [`REG_IDX_W-1:0] dbg_sel,
  output logic [`XLEN-1:0]      dbg_data,
  output wb_t                   wb
);

  logic [`REG_IDX_W-1:0] rs1_idx;
  logic [`REG_IDX_W-1:0] rs2_idx;
  logic [`XLEN-1:0]      rs1_data;
  logic [`XLEN-1:0]      rs2_data;
  id_ex_t                id_ex;
  wb_t                   ex_result;

  // *************************************************************************
  // Fetch and decode
  // *************************************************************************

  fetch_counter u_fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_address (fetch_address)
  );

  decode_stage u_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr     (instr),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .ex_result (ex_result),
    .wb        (wb),
    .id_ex     (id_ex)
  );

  register_file u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb),
    .dbg_sel  (dbg_sel),
    .dbg_data (dbg_data)
  );

  // Execute and writeback
  execute_stage u_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .id_ex     (id_ex),
    .ex_result (ex_result),
    .wb        (wb)
  );

endmodule

// File: verilog/execute_stage.sv
`include "rv_config.svh"

module execute_stage
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  id_ex_t id_ex,
  output wb_t    ex_result,
  output wb_t    wb
);

  id_ex_t           id_ex_q;
  logic             sub;
  logic [`XLEN-1:0] b_operand;
  logic [`XLEN-1:0] sum;

  // ID/EX register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex_q <= '0;
    end else begin
      id_ex_q <= id_ex;
    end
  end

  // *************************************************************************
  // Add/subtract unit
  // *************************************************************************

  // Subtract as a + ~b + 1
  assign sub       = (id_ex_q.alu_op == ALU_SUB);
  assign b_operand = sub ? ~id_ex_q.b : id_ex_q.b;
  assign sum       = id_ex_q.a + b_operand + {{(`XLEN-1){1'b0}}, sub};

  always_comb begin
    ex_result.valid = id_ex_q.valid;
    ex_result.rd    = id_ex_q.rd;
    ex_result.data  = (id_ex_q.alu_op == ALU_PASS_B) ? id_ex_q.b : sum;
  end

  // Writeback register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb <= '0;
    end else begin
      wb <= ex_result;
    end
  end

endmodule

// File: verilog/register_file.sv
`include "rv_config.svh"

module register_file
  import rv_pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`REG_IDX_W-1:0] rs1_idx,
  input  logic [`REG_IDX_W-1:0] rs2_idx,
  output logic [`XLEN-1:0]      rs1_data,
  output logic [`XLEN-1:0]      rs2_data,
  input  wb_t                   wb,
  input  logic [`REG_IDX_W-1:0] dbg_sel,
  output logic [`XLEN-1:0]      dbg_data
);

  // x0 has no storage
  logic [`XLEN-1:0] regs_q [1:`REG_COUNT-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb.valid && wb.rd != '0) begin
      regs_q[wb.rd] <= wb.data;
    end
  end

  // Pending write is visible in the same cycle
  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_IDX_W-1:0] idx);
    logic [`XLEN-1:0] data;
    if (idx == '0) begin
      data = '0;
    end else if (wb.valid && wb.rd == idx) begin
      data = wb.data;
    end else begin
      data = regs_q[idx];
    end
    return data;
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_idx);
    rs2_data = read_port(rs2_idx);
    dbg_data = read_port(dbg_sel);
  end

  // Decode drops x0 destinations upstream
  a_no_x0_write : assert property (
    @(posedge clk) disable iff (!rst_n)
    wb.valid |-> wb.rd != '0
  ) else $error("write strobe targets x0");

endmodule

// File: verilog/decode_stage.sv
`include "rv_config.svh"

module decode_stage
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`XLEN-1:0]      instr,
  output logic [`REG_IDX_W-1:0] rs1_idx,
  output logic [`REG_IDX_W-1:0] rs2_idx,
  input  logic [`XLEN-1:0]      rs1_data,
  input  logic [`XLEN-1:0]      rs2_data,
  input  wb_t                   ex_result,
  input  wb_t                   wb,
  output id_ex_t                id_ex
);

  instr_fields_t    instr_q;
  opcode_e          opcode;
  alu_op_e          alu_op;
  logic             supported;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] rs1_fwd;
  logic [`XLEN-1:0] rs2_fwd;

  // Youngest producer first, register file read last
  function automatic logic [`XLEN-1:0] bypass(
    input logic [`REG_IDX_W-1:0] idx,
    input logic [`XLEN-1:0]      rf_data,
    input wb_t                   ex_src,
    input wb_t                   wb_src
  );
    logic [`XLEN-1:0] data;
    if (ex_src.valid && ex_src.rd == idx) begin
      data = ex_src.data;
    end else if (wb_src.valid && wb_src.rd == idx) begin
      data = wb_src.data;
    end else begin
      data = rf_data;
    end
    return data;
  endfunction

  // *************************************************************************
  // Decode register
  // *************************************************************************

  // All-zero word decodes as a no-op
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr_q <= '0;
    end else begin
      instr_q <= instr_fields_t'(instr);
    end
  end

  assign opcode  = opcode_e'(instr_q.opcode);
  assign rs1_idx = instr_q.rs1;
  assign rs2_idx = instr_q.rs2;

  // *************************************************************************
  // Operation and immediate decode
  // *************************************************************************

  always_comb begin
    supported = 1'b0;
    alu_op    = ALU_ADD;
    // I-type, sign bit is instr[31]
    imm       = {{(`XLEN-12){instr_q.funct7[6]}}, instr_q.funct7, instr_q.rs2};
    case (opcode)
      OPC_OP: begin
        supported = (instr_q.funct3 == F3_ADD_SUB);
        // instr[30] selects SUB
        alu_op    = instr_q.funct7[5] ? ALU_SUB : ALU_ADD;
      end
      OPC_OP_IMM: begin
        supported = (instr_q.funct3 == F3_ADD_SUB);
      end
      OPC_LUI: begin
        supported = 1'b1;
        alu_op    = ALU_PASS_B;
        imm       = {instr_q.funct7, instr_q.rs2, instr_q.rs1, instr_q.funct3, 12'b0};
      end
      default: begin
        supported = 1'b0;
      end
    endcase
  end

  assign rs1_fwd = bypass(instr_q.rs1, rs1_data, ex_result, wb);
  assign rs2_fwd = bypass(instr_q.rs2, rs2_data, ex_result, wb);

  always_comb begin
    id_ex.valid  = supported && (instr_q.rd != '0);
    id_ex.rd     = instr_q.rd;
    id_ex.alu_op = alu_op;
    id_ex.a      = (opcode == OPC_LUI) ? '0 : rs1_fwd;
    id_ex.b      = (opcode == OPC_OP) ? rs2_fwd : imm;
  end

  a_no_x0_dest : assert property (
    @(posedge clk) disable iff (!rst_n)
    id_ex.valid |-> id_ex.rd != '0
  ) else $error("valid instruction targets x0");

endmodule

// File: verilog/fetch_counter.sv
`include "rv_config.svh"

module fetch_counter (
  input  logic             clk,
  input  logic             rst_n,
  output logic [`XLEN-1:0] fetch_address
);

  localparam logic [`XLEN-1:0] STEP     = `PC_STEP;
  localparam logic [`XLEN-1:0] START_PC = `RESET_PC;

  logic [`XLEN-1:0] pc_q;

  // No branches, so the PC only steps
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= START_PC;
    end else begin
      pc_q <= pc_q + STEP;
    end
  end

  assign fetch_address = pc_q;

  // Address advances by one step on every cycle out of reset
  a_pc_step : assert property (
    @(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> fetch_address == $past(fetch_address) + STEP
  ) else $error("fetch_address did not advance by one step");

endmodule

// File: verilog/rv_pipe_pkg.sv
`include "rv_config.svh"

package rv_pipe_pkg;

  import rv_isa_pkg::*;

  // *************************************************************************
  // Stage to stage records
  // *************************************************************************

  // Decoded instruction with resolved operands
  typedef struct packed {
    logic                  valid;
    logic [`REG_IDX_W-1:0] rd;
    alu_op_e               alu_op;
    logic [`XLEN-1:0]      a;
    logic [`XLEN-1:0]      b;
  } id_ex_t;

  // Result on its way to the register file
  // Also used as bypass source
  typedef struct packed {
    logic                  valid;
    logic [`REG_IDX_W-1:0] rd;
    logic [`XLEN-1:0]      data;
  } wb_t;

  // Record widths checked at elaboration
  localparam int ID_EX_W = $bits(id_ex_t);
  localparam int WB_W    = $bits(wb_t);

  typedef logic [ID_EX_W-1:0] id_ex_bits_t;
  typedef logic [WB_W-1:0]    wb_bits_t;

endpackage

// File: verilog/rv_isa_pkg.sv
`include "rv_config.svh"

package rv_isa_pkg;

  // *************************************************************************
  // Major opcodes handled by the core
  // *************************************************************************

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // Shared by ADD, SUB and ADDI
  localparam logic [2:0] F3_ADD_SUB = 3'b000;

  // Operations of the execute adder
  typedef enum logic [1:0] {
    ALU_ADD    = 2'b00,
    ALU_SUB    = 2'b01,
    ALU_PASS_B = 2'b10
  } alu_op_e;

  // *************************************************************************
  // R-type field layout, msb first
  // *************************************************************************

  typedef struct packed {
    logic [6:0]            funct7;
    logic [`REG_IDX_W-1:0] rs2;
    logic [`REG_IDX_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [`REG_IDX_W-1:0] rd;
    logic [6:0]            opcode;
  } instr_fields_t;

endpackage

// File: verilog/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// *************************************************************************
// Core geometry
// *************************************************************************

// Data path and instruction word width
`define XLEN      32

// Architectural registers, x0 included
`define REG_COUNT 32
`define REG_IDX_W 5

// Fetch sequencing
`define PC_STEP   4
`define RESET_PC  0

`endif
